/* dv/simd_alu_sva.sv */
`timescale 1ns/1ps

module simd_alu_sva import simd_alu_pkg::*; (
  input logic  clk_i,
  input logic  arst_n_i,
  input logic  valid_i,
  input logic  valid_o,
  input strb_t vxsat_o
);

  // Output strobe held low in reset
  property p_idle_in_reset;
    @(posedge clk_i) !arst_n_i |-> !valid_o;
  endproperty

  // Two register stages from input to output
  property p_valid_latency;
    @(posedge clk_i) disable iff (!arst_n_i) valid_o == $past(valid_i, 2);
  endproperty

  property p_vxsat_quiet;
    @(posedge clk_i) !valid_o |-> vxsat_o == '0;
  endproperty

  a_idle_in_reset: assert property (p_idle_in_reset)
    else $error("valid_o high while reset is asserted");
  a_valid_latency: assert property (p_valid_latency)
    else $error("valid_o does not follow valid_i by two cycles");
  a_vxsat_quiet: assert property (p_vxsat_quiet)
    else $error("vxsat_o nonzero while valid_o is low");

endmodule

bind simd_alu simd_alu_sva u_sva (
  .clk_i   (clk_i),
  .arst_n_i(arst_n_i),
  .valid_i (valid_i),
  .valid_o (valid_o),
  .vxsat_o (vxsat_o)
);

/* dv/simd_alu_tb.sv */
`timescale 1ns/1ps
`include "simd_alu_settings.svh"

module simd_alu_tb import simd_alu_pkg::*; ();

  localparam int ResetCycles = 16;
  localparam int NumRandom   = 40;

  typedef struct packed {
    alu_op_e op;
    vew_e    vew;
    vxrm_e   vxrm;
    elen_t   a;
    elen_t   b;
    elen_t   res;
    strb_t   sat;
  } vec_t;

  typedef struct packed {
    elen_t       res;
    strb_t       sat;
    logic [31:0] idx;
    logic [31:0] due;
  } exp_t;

  logic        clk;
  logic        arst_n;
  logic        valid_i;
  alu_op_e     op_i;
  vew_e        vew_i;
  vxrm_e       vxrm_i;
  elen_t       operand_a_i;
  elen_t       operand_b_i;
  logic        valid_o;
  elen_t       result_o;
  strb_t       vxsat_o;

  vec_t        vec_tbl[$];
  exp_t        exp_q[$];
  int unsigned num_directed = 0;
  logic [31:0] cycle;
  int          res_errs;
  int          sat_errs;
  int          seq_errs;

  simd_alu uut (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .vew_i      (vew_i),
    .vxrm_i     (vxrm_i),
    .operand_a_i(operand_a_i),
    .operand_b_i(operand_b_i),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .vxsat_o    (vxsat_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 32'd1;

  task automatic add_vec(input alu_op_e op, input vew_e vew, input vxrm_e rm,
                         input elen_t a, input elen_t b,
                         input elen_t res, input strb_t sat);
    vec_t v;
    v = {op, vew, rm, a, b, res, sat};
    vec_tbl.push_back(v);
  endtask

  // Reference for the random ops, element by element
  function automatic elen_t model_word(alu_op_e op, vew_e vew, elen_t a, elen_t b);
    int unsigned ew;
    int unsigned sh;
    int          i;
    elen_t       mask;
    elen_t       ea;
    elen_t       eb;
    elen_t       er;
    elen_t       word;
    ew   = 8 << vew;
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    word = '0;
    for (i = 0; i < `SIMD_ALU_DATA_W / ew; i++) begin
      ea = (a >> (i * ew)) & mask;
      eb = (b >> (i * ew)) & mask;
      sh = ea % ew;
      case (op)
        VAND:    er = ea & eb;
        VOR:     er = ea | eb;
        VXOR:    er = ea ^ eb;
        VADD:    er = ea + eb;
        VSLL:    er = eb << sh;
        VSRL:    er = eb >> sh;
        // Sign bits filled above the element first
        VSRA:    er = $signed(eb[ew-1] ? (eb | ~mask) : eb) >>> sh;
        default: er = '0;
      endcase
      word = word | ((er & mask) << (i * ew));
    end
    return word;
  endfunction

  task automatic add_random(input int count);
    alu_op_e op;
    vew_e    vew;
    elen_t   a;
    elen_t   b;
    int      n;
    for (n = 0; n < count; n++) begin
      case ($urandom % 7)
        0:       op = VAND;
        1:       op = VOR;
        2:       op = VXOR;
        3:       op = VADD;
        4:       op = VSLL;
        5:       op = VSRL;
        default: op = VSRA;
      endcase
      vew = vew_e'($urandom % 4);
      a   = {$urandom, $urandom};
      b   = {$urandom, $urandom};
      add_vec(op, vew, RNU, a, b, model_word(op, vew, a, b), 8'h00);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed table

  task automatic build_directed();
    add_vec(VAND, EW8, RNU, 64'hF0F0_F0F0_FF00_FF00, 64'h0FF0_FF00_F0F0_1234,
            64'h00F0_F000_F000_1200, 8'h00);
    add_vec(VOR, EW16, RNU, 64'h1234_0000_FFFF_00F0, 64'h0000_5678_0000_0F0F,
            64'h1234_5678_FFFF_0FFF, 8'h00);
    add_vec(VXOR, EW64, RNU, 64'hFFFF_0000_AAAA_5555, 64'h0F0F_0F0F_FFFF_FFFF,
            64'hF0F0_0F0F_5555_AAAA, 8'h00);
    // Carries stop at element edges
    add_vec(VADD, EW8, RNU, 64'hFF01_80FF_7F00_0102, 64'h01FF_8001_0100_0304,
            64'h0000_0000_8000_0406, 8'h00);
    add_vec(VADD, EW32, RNU, 64'hFFFF_FFFF_0000_0001, 64'h0000_0001_7FFF_FFFF,
            64'h0000_0000_8000_0000, 8'h00);
    add_vec(VADD, EW64, RNU, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0002,
            64'h0000_0000_0000_0001, 8'h00);
    add_vec(VSUB, EW8, RNU, 64'h0102_0304_0506_0708, 64'h0005_0310_FF00_8008,
            64'hFF03_000C_FAFA_7900, 8'h00);
    add_vec(VRSUB, EW16, RNU, 64'h0000_1000_8000_0005, 64'h0001_0001_0001_0005,
            64'hFFFF_0FFF_7FFF_0000, 8'h00);
    // Saturation, flags per element
    add_vec(VSADDU, EW8, RNU, 64'hFF80_1001_00FE_7FC0, 64'h0180_20FE_0001_8040,
            64'hFFFF_30FF_00FF_FFFF, 8'hC1);
    add_vec(VSADD, EW16, RNU, 64'h7FFF_8000_0001_C000, 64'h0001_FFFF_0002_C000,
            64'h7FFF_8000_0003_8000, 8'hF0);
    add_vec(VSSUBU, EW32, RNU, 64'h0000_0010_0000_0001, 64'h0000_0005_FFFF_FFFF,
            64'h0000_0000_FFFF_FFFE, 8'hF0);
    add_vec(VSSUB, EW8, RNU, 64'h01FF_8001_0000_0000, 64'h807F_0005_0000_0000,
            64'h807F_7F04_0000_0000, 8'hE0);
    add_vec(VSADD, EW64, RNU, 64'h7FFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0001,
            64'h7FFF_FFFF_FFFF_FFFF, 8'hFF);
    // Sums of 5 and 7 split the four modes
    add_vec(VAADDU, EW8, RNU, 64'h0000_0000_FFFF_0302, 64'h0000_0000_02FF_0403,
            64'h0000_0000_81FF_0403, 8'h00);
    add_vec(VAADDU, EW8, RNE, 64'h0000_0000_FFFF_0302, 64'h0000_0000_02FF_0403,
            64'h0000_0000_80FF_0402, 8'h00);
    add_vec(VAADDU, EW8, RDN, 64'h0000_0000_FFFF_0302, 64'h0000_0000_02FF_0403,
            64'h0000_0000_80FF_0302, 8'h00);
    add_vec(VAADDU, EW8, ROD, 64'h0000_0000_FFFF_0302, 64'h0000_0000_02FF_0403,
            64'h0000_0000_81FF_0303, 8'h00);
    add_vec(VAADD, EW16, RNE, 64'h0000_7FFF_8000_FFFD, 64'h0000_0002_8000_FFFE,
            64'h0000_4000_8000_FFFE, 8'h00);
    add_vec(VAADD, EW16, ROD, 64'h0000_7FFF_8000_FFFD, 64'h0000_0002_8000_FFFE,
            64'h0000_4001_8000_FFFD, 8'h00);
    // Upper shift-amount bits ignored
    add_vec(VSLL, EW8, RNU, 64'h090F_F800_0102_0307, 64'h81FF_5580_8080_8001,
            64'h0280_5580_0000_0080, 8'h00);
    add_vec(VSRL, EW16, RNU, 64'h0014_0001_FFFF_0000, 64'h8000_8000_8000_1234,
            64'h0800_4000_0001_1234, 8'h00);
    add_vec(VSRA, EW16, RNU, 64'h0014_0001_FFFF_0000, 64'h8000_8000_8000_1234,
            64'hF800_C000_FFFF_1234, 8'h00);
    add_vec(VSRA, EW32, RNU, 64'h0000_0023_0000_0004, 64'h8000_0000_7000_0000,
            64'hF000_0000_0700_0000, 8'h00);
    add_vec(VSRL, EW64, RNU, 64'h0000_0000_0000_0044, 64'hF000_0000_0000_0000,
            64'h0F00_0000_0000_0000, 8'h00);
    add_vec(VMINU, EW8, RNU, 64'h807F_01FF_0000_0000, 64'h7F80_FF01_0000_0000,
            64'h7F7F_0101_0000_0000, 8'h00);
    add_vec(VMIN, EW8, RNU, 64'h807F_01FF_0000_0000, 64'h7F80_FF01_0000_0000,
            64'h8080_FFFF_0000_0000, 8'h00);
    add_vec(VMAXU, EW8, RNU, 64'h807F_01FF_0000_0000, 64'h7F80_FF01_0000_0000,
            64'h8080_FFFF_0000_0000, 8'h00);
    add_vec(VMAX, EW8, RNU, 64'h807F_01FF_0000_0000, 64'h7F80_FF01_0000_0000,
            64'h7F7F_0101_0000_0000, 8'h00);
    add_vec(VMSEQ, EW16, RNU, 64'h8000_0001_1234_FFFF, 64'h7FFF_0001_1233_0000,
            64'h0000_0001_0000_0000, 8'h00);
    add_vec(VMSNE, EW16, RNU, 64'h8000_0001_1234_FFFF, 64'h7FFF_0001_1233_0000,
            64'h0001_0000_0001_0001, 8'h00);
    add_vec(VMSLTU, EW16, RNU, 64'h8000_0001_1234_FFFF, 64'h7FFF_0001_1233_0000,
            64'h0001_0000_0001_0001, 8'h00);
    add_vec(VMSLT, EW16, RNU, 64'h8000_0001_1234_FFFF, 64'h7FFF_0001_1233_0000,
            64'h0000_0000_0001_0000, 8'h00);
    add_vec(OP_NONE, EW32, RNU, 64'h1234_5678_9ABC_DEF0, 64'hFFFF_FFFF_FFFF_FFFF,
            64'h0000_0000_0000_0000, 8'h00);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    vec_t        v;
    exp_t        e;
    int          n;
    int unsigned seed_draw;
    valid_i     = 1'b0;
    op_i        = OP_NONE;
    vew_i       = EW8;
    vxrm_i      = RNU;
    operand_a_i = '0;
    operand_b_i = '0;
    arst_n      = 1'b0;
    cycle       = '0;
    res_errs    = 0;
    sat_errs    = 0;
    seq_errs    = 0;
    seed_draw   = $urandom(32'hd4a5);
    build_directed();
    num_directed = vec_tbl.size();
    add_random(NumRandom);
    repeat (ResetCycles) @(posedge clk);
    arst_n <= 1'b1;
    for (n = 0; n < vec_tbl.size(); n++) begin
      @(posedge clk);
      v = vec_tbl[n];
      valid_i     <= 1'b1;
      op_i        <= v.op;
      vew_i       <= v.vew;
      vxrm_i      <= v.vxrm;
      operand_a_i <= v.a;
      operand_b_i <= v.b;
      // Sampled on the next edge, out two edges after that
      e = {v.res, v.sat, n, cycle + 32'd3};
      exp_q.push_back(e);
    end
    @(posedge clk);
    valid_i <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("Errors: result %0d, vxsat %0d, sequence %0d", res_errs, sat_errs, seq_errs);
    if (res_errs + sat_errs + seq_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard, sampled mid-cycle

  always @(negedge clk) begin : check_outputs
    exp_t want;
    if (arst_n && valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Result appeared with no operation outstanding at %0t", $time);
        seq_errs++;
      end else begin
        want = exp_q.pop_front();
        assert (result_o === want.res) else begin
          $display("FAIL result_o entry %0d: got 0x%h, expected 0x%h",
                   want.idx, result_o, want.res);
          res_errs++;
        end
        assert (vxsat_o === want.sat) else begin
          $display("FAIL vxsat_o entry %0d: got 0x%h, expected 0x%h",
                   want.idx, vxsat_o, want.sat);
          sat_errs++;
        end
        assert (cycle == want.due) else begin
          $display("Entry %0d came out in cycle %0d instead of cycle %0d",
                   want.idx, cycle, want.due);
          seq_errs++;
        end
      end
    end
  end

  initial begin : watchdog
    int unsigned limit_ns;
    wait (num_directed != 0);
    limit_ns = 2 * 10 * (num_directed + NumRandom + ResetCycles + 10);
    #(limit_ns);
    $display("Timeout: run still busy after %0d ns", limit_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* hdl/alu_op_decoder.sv */
`timescale 1ns/1ps

module alu_op_decoder import simd_alu_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      valid_i,
  input  alu_op_e   op_i,
  input  vew_e      vew_i,
  input  vxrm_e     vxrm_i,
  input  elen_t     operand_a_i,
  input  elen_t     operand_b_i,
  output logic      valid_o,
  output vew_e      vew_o,
  output vxrm_e     vxrm_o,
  output elen_t     operand_a_o,
  output elen_t     operand_b_o,
  output op_class_e op_class_o,
  output logic_fn_e logic_fn_o,
  output logic      is_signed_o,
  output logic      saturate_o,
  output logic      select_max_o,
  output logic      invert_o
);

  op_class_e op_class_d;
  logic_fn_e logic_fn_d;
  logic      is_signed_d;
  logic      saturate_d;
  logic      select_max_d;
  logic      invert_d;

  // Operation code to lane controls
  always_comb begin
    case (op_i)
      VAND, VOR, VXOR:             op_class_d = CLS_LOGIC;
      VADD, VSADDU, VSADD:         op_class_d = CLS_ADD;
      VSUB, VSSUBU, VSSUB:         op_class_d = CLS_SUB;
      VRSUB:                       op_class_d = CLS_RSUB;
      VAADDU, VAADD:               op_class_d = CLS_AVG;
      VSLL:                        op_class_d = CLS_SHL;
      VSRL, VSRA:                  op_class_d = CLS_SHR;
      VMINU, VMIN, VMAXU, VMAX:    op_class_d = CLS_MINMAX;
      VMSEQ, VMSNE:                op_class_d = CLS_CMPEQ;
      VMSLTU, VMSLT:               op_class_d = CLS_CMPLT;
      default:                     op_class_d = CLS_NONE;
    endcase
    logic_fn_d   = (op_i == VOR) ? FN_OR : ((op_i == VXOR) ? FN_XOR : FN_AND);
    is_signed_d  = op_i inside {VSADD, VSSUB, VAADD, VSRA, VMIN, VMAX, VMSLT};
    saturate_d   = op_i inside {VSADDU, VSADD, VSSUBU, VSSUB};
    select_max_d = op_i inside {VMAXU, VMAX};
    // Equality turned into inequality
    invert_d     = (op_i == VMSNE);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o      <= 1'b0;
      op_class_o   <= CLS_NONE;
      logic_fn_o   <= FN_AND;
      is_signed_o  <= 1'b0;
      saturate_o   <= 1'b0;
      select_max_o <= 1'b0;
      invert_o     <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        op_class_o   <= op_class_d;
        logic_fn_o   <= logic_fn_d;
        is_signed_o  <= is_signed_d;
        saturate_o   <= saturate_d;
        select_max_o <= select_max_d;
        invert_o     <= invert_d;
      end
    end
  end

  // Operand registers
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      vew_o       <= vew_i;
      vxrm_o      <= vxrm_i;
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
    end
  end

endmodule

/* hdl/alu_result_stage.sv */
`timescale 1ns/1ps

module alu_result_stage import simd_alu_pkg::*; (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  valid_i,
  input  elen_t result_i,
  input  strb_t vxsat_i,
  output logic  valid_o,
  output elen_t result_o,
  output strb_t vxsat_o
);

  // Valid and saturation flags
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      vxsat_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        vxsat_o <= vxsat_i;
      end else begin
        // Flags only meaningful alongside a result
        vxsat_o <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= result_i;
    end
  end

endmodule

/* hdl/simd_alu.sv */
`timescale 1ns/1ps

module simd_alu import simd_alu_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    valid_i,
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  input  vxrm_e   vxrm_i,
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  output logic    valid_o,
  output elen_t   result_o,
  output strb_t   vxsat_o
);

  logic      dec_valid;
  vew_e      dec_vew;
  vxrm_e     dec_vxrm;
  elen_t     dec_op_a;
  elen_t     dec_op_b;
  op_class_e dec_op_class;
  logic_fn_e dec_logic_fn;
  logic      dec_is_signed;
  logic      dec_saturate;
  logic      dec_select_max;
  logic      dec_invert;
  elen_t     exe_result;
  strb_t     exe_vxsat;

  // Decode stage
  alu_op_decoder u_decoder (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .vxrm_i      (vxrm_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (dec_valid),
    .vew_o       (dec_vew),
    .vxrm_o      (dec_vxrm),
    .operand_a_o (dec_op_a),
    .operand_b_o (dec_op_b),
    .op_class_o  (dec_op_class),
    .logic_fn_o  (dec_logic_fn),
    .is_signed_o (dec_is_signed),
    .saturate_o  (dec_saturate),
    .select_max_o(dec_select_max),
    .invert_o    (dec_invert)
  );

  // Execute, combinational
  simd_lane_array u_lanes (
    .vew_i       (dec_vew),
    .operand_a_i (dec_op_a),
    .operand_b_i (dec_op_b),
    .op_class_i  (dec_op_class),
    .logic_fn_i  (dec_logic_fn),
    .vxrm_i      (dec_vxrm),
    .is_signed_i (dec_is_signed),
    .saturate_i  (dec_saturate),
    .select_max_i(dec_select_max),
    .invert_i    (dec_invert),
    .result_o    (exe_result),
    .vxsat_o     (exe_vxsat)
  );

  alu_result_stage u_result (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (dec_valid),
    .result_i(exe_result),
    .vxsat_i (exe_vxsat),
    .valid_o (valid_o),
    .result_o(result_o),
    .vxsat_o (vxsat_o)
  );

endmodule

/* hdl/simd_alu_pkg.sv */
`include "simd_alu_settings.svh"

package simd_alu_pkg;

  typedef logic [`SIMD_ALU_DATA_W-1:0] elen_t;
  typedef logic [`SIMD_ALU_STRB_W-1:0] strb_t;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;

  // Fixed-point rounding modes
  typedef enum logic [1:0] {RNU, RNE, RDN, ROD} vxrm_e;

  typedef enum logic [4:0] {
    OP_NONE,
    VAND, VOR, VXOR,
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VAADDU, VAADD,
    VSLL, VSRL, VSRA,
    VMINU, VMIN, VMAXU, VMAX,
    VMSEQ, VMSNE, VMSLTU, VMSLT
  } alu_op_e;

  // Lane datapath selection
  typedef enum logic [3:0] {
    CLS_LOGIC, CLS_ADD, CLS_SUB, CLS_RSUB, CLS_AVG, CLS_SHL,
    CLS_SHR, CLS_MINMAX, CLS_CMPEQ, CLS_CMPLT, CLS_NONE
  } op_class_e;

  typedef enum logic [1:0] {FN_AND, FN_OR, FN_XOR} logic_fn_e;

endpackage

/* hdl/simd_alu_settings.svh */
`ifndef SIMD_ALU_SETTINGS_SVH
`define SIMD_ALU_SETTINGS_SVH

// Datapath
`define SIMD_ALU_DATA_W 64
`define SIMD_ALU_STRB_W (`SIMD_ALU_DATA_W / 8)

// Lanes per element width
`define SIMD_ALU_EW8_N  8
`define SIMD_ALU_EW16_N 4
`define SIMD_ALU_EW32_N 2
`define SIMD_ALU_EW64_N 1

`endif

/* hdl/simd_lane.sv */
`timescale 1ns/1ps

module simd_lane import simd_alu_pkg::*; #(
  parameter int unsigned ElemWidth = 8
) (
  input  logic [ElemWidth-1:0] op_a_i,
  input  logic [ElemWidth-1:0] op_b_i,
  input  op_class_e            op_class_i,
  input  logic_fn_e            logic_fn_i,
  input  vxrm_e                vxrm_i,
  input  logic                 is_signed_i,
  input  logic                 saturate_i,
  input  logic                 select_max_i,
  input  logic                 invert_i,
  output logic [ElemWidth-1:0] res_o,
  output logic                 sat_o
);

  localparam int unsigned ShiftW = $clog2(ElemWidth);

  logic                        ext_a;
  logic                        ext_b;
  logic [ElemWidth:0]          sum;
  logic [ElemWidth:0]          diff;
  logic                        sum_ovf;
  logic                        diff_ovf;
  logic [ElemWidth-1:0]        sum_clamp;
  logic [ElemWidth-1:0]        diff_clamp;
  logic                        round_inc;
  logic [ShiftW-1:0]           shamt;
  logic [ElemWidth-1:0]        shr_log;
  logic signed [ElemWidth-1:0] shr_ari;
  logic                        less;
  logic                        equal;

  ////////////////////////////////////////////////////////////
  // Extended add and subtract

  // One extra bit, sign or zero
  assign ext_a = is_signed_i & op_a_i[ElemWidth-1];
  assign ext_b = is_signed_i & op_b_i[ElemWidth-1];
  assign sum   = {ext_a, op_a_i} + {ext_b, op_b_i};
  assign diff  = {ext_b, op_b_i} - {ext_a, op_a_i};

  // Signed overflow when the two top bits disagree
  assign sum_ovf  = is_signed_i ? ^sum[ElemWidth -: 2] : sum[ElemWidth];
  assign diff_ovf = is_signed_i ? ^diff[ElemWidth -: 2] : diff[ElemWidth];

  // Top bit of the extended result gives the clamp direction
  assign sum_clamp  = is_signed_i ? {sum[ElemWidth], {(ElemWidth-1){~sum[ElemWidth]}}} : '1;
  assign diff_clamp = is_signed_i ? {diff[ElemWidth], {(ElemWidth-1){~diff[ElemWidth]}}} : '0;

  // Increment applied after the halving shift
  always_comb begin
    case (vxrm_i)
      RNU:     round_inc = sum[0];
      RNE:     round_inc = sum[0] & sum[1];
      ROD:     round_inc = sum[0] & ~sum[1];
      default: round_inc = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Shifts and compares

  assign shamt   = op_a_i[ShiftW-1:0];
  assign shr_log = op_b_i >> shamt;
  assign shr_ari = $signed(op_b_i) >>> shamt;

  // b < a, read off the borrow of the extended difference
  assign less  = diff[ElemWidth];
  assign equal = (op_a_i == op_b_i);

  always_comb begin
    res_o = '0;
    case (op_class_i)
      CLS_LOGIC: begin
        case (logic_fn_i)
          FN_AND:  res_o = op_a_i & op_b_i;
          FN_OR:   res_o = op_a_i | op_b_i;
          FN_XOR:  res_o = op_a_i ^ op_b_i;
          default: res_o = '0;
        endcase
      end
      CLS_ADD:    res_o = (saturate_i && sum_ovf) ? sum_clamp : sum[ElemWidth-1:0];
      CLS_SUB:    res_o = (saturate_i && diff_ovf) ? diff_clamp : diff[ElemWidth-1:0];
      CLS_RSUB:   res_o = op_a_i - op_b_i;
      CLS_AVG:    res_o = sum[ElemWidth:1] + ElemWidth'(round_inc);
      CLS_SHL:    res_o = op_b_i << shamt;
      CLS_SHR:    res_o = is_signed_i ? shr_ari : shr_log;
      CLS_MINMAX: res_o = (less ^ select_max_i) ? op_b_i : op_a_i;
      CLS_CMPEQ:  res_o[0] = equal ^ invert_i;
      CLS_CMPLT:  res_o[0] = less;
      default:    res_o = '0;
    endcase
  end

  assign sat_o = saturate_i & (((op_class_i == CLS_ADD) & sum_ovf) |
                               ((op_class_i == CLS_SUB) & diff_ovf));

endmodule

/* hdl/simd_lane_array.sv */
`timescale 1ns/1ps
`include "simd_alu_settings.svh"

module simd_lane_array import simd_alu_pkg::*; (
  input  vew_e      vew_i,
  input  elen_t     operand_a_i,
  input  elen_t     operand_b_i,
  input  op_class_e op_class_i,
  input  logic_fn_e logic_fn_i,
  input  vxrm_e     vxrm_i,
  input  logic      is_signed_i,
  input  logic      saturate_i,
  input  logic      select_max_i,
  input  logic      invert_i,
  output elen_t     result_o,
  output strb_t     vxsat_o
);

  localparam int unsigned NumWidths = 4;
  localparam int unsigned LaneCount [NumWidths] = '{
    `SIMD_ALU_EW8_N, `SIMD_ALU_EW16_N, `SIMD_ALU_EW32_N, `SIMD_ALU_EW64_N
  };

  elen_t [NumWidths-1:0] width_res;
  strb_t [NumWidths-1:0] width_sat;

  ////////////////////////////////////////////////////////////
  // Lanes for every element width

  for (genvar w = 0; w < NumWidths; w++) begin : g_width
    localparam int unsigned ElemW = `SIMD_ALU_DATA_W / LaneCount[w];
    localparam int unsigned ElemB = ElemW / 8;
    for (genvar l = 0; l < LaneCount[w]; l++) begin : g_lane
      logic lane_sat;
      simd_lane #(
        .ElemWidth(ElemW)
      ) u_lane (
        .op_a_i      (operand_a_i[l*ElemW +: ElemW]),
        .op_b_i      (operand_b_i[l*ElemW +: ElemW]),
        .op_class_i  (op_class_i),
        .logic_fn_i  (logic_fn_i),
        .vxrm_i      (vxrm_i),
        .is_signed_i (is_signed_i),
        .saturate_i  (saturate_i),
        .select_max_i(select_max_i),
        .invert_i    (invert_i),
        .res_o       (width_res[w][l*ElemW +: ElemW]),
        .sat_o       (lane_sat)
      );
      // Flag spread over the lane's bytes
      assign width_sat[w][l*ElemB +: ElemB] = {ElemB{lane_sat}};
    end
  end

  ////////////////////////////////////////////////////////////
  // Active width select

  always_comb begin
    result_o = '0;
    vxsat_o  = '0;
    case (vew_i)
      EW8: begin
        result_o = width_res[0];
        vxsat_o  = width_sat[0];
      end
      EW16: begin
        result_o = width_res[1];
        vxsat_o  = width_sat[1];
      end
      EW32: begin
        result_o = width_res[2];
        vxsat_o  = width_sat[2];
      end
      EW64: begin
        result_o = width_res[3];
        vxsat_o  = width_sat[3];
      end
      default: begin
        result_o = '0;
        vxsat_o  = '0;
      end
    endcase
  end

endmodule

/* src.f */
+incdir+hdl
hdl/simd_alu_pkg.sv
hdl/alu_op_decoder.sv
hdl/simd_lane.sv
hdl/simd_lane_array.sv
hdl/alu_result_stage.sv
hdl/simd_alu.sv
dv/simd_alu_sva.sv
dv/simd_alu_tb.sv
